//--- test/execVectors.txt
// instr    loadData expV0    expAddr  flags    test
// flags: bit0 instrValid, bit1 expected illegalInstr, bit2 check memAddress
// test 1: ori into r0, then addu r0+r0 into v0
34001234 00000000 00000000 00000000 00000001 00000001
00001021 00000000 00000000 00000000 00000001 00000001
// test 2: r8 = 12345678, r9 = 0f0f00ff, r10 = 80000000, then alu ops into v0
3C081234 00000000 00000000 00000000 00000001 00000002
35085678 00000000 00000000 00000000 00000001 00000002
3C090F0F 00000000 00000000 00000000 00000001 00000002
352900FF 00000000 00000000 00000000 00000001 00000002
01091021 00000000 21435777 00000000 00000001 00000002
01281023 00000000 FCDAAA87 00000000 00000001 00000002
01091024 00000000 02040078 00000000 00000001 00000002
01091025 00000000 1F3F56FF 00000000 00000001 00000002
01091026 00000000 1D3B5687 00000000 00000001 00000002
2502FFFF 00000000 12345677 00000000 00000001 00000002
3C0A8000 00000000 12345677 00000000 00000001 00000002
0148102A 00000000 00000001 00000000 00000001 00000002
010A102A 00000000 00000000 00000000 00000001 00000002
0128102A 00000000 00000001 00000000 00000001 00000002
// test 3: lw with positive and negative offsets, last one into r11
8D020010 CAFEF00D CAFEF00D 12345688 00000005 00000003
8D22FFF8 89ABCDEF 89ABCDEF 0F0F00F7 00000005 00000003
8C0B0004 55AA55AA 89ABCDEF 00000004 00000005 00000003
// test 4: preset v0 = 11223344, then lwl and lwr at offsets 0 to 3
3C021122 00000000 11220000 00000000 00000001 00000004
34423344 00000000 11223344 00000000 00000001 00000004
88020000 AABBCCDD DD223344 00000000 00000005 00000004
88020001 01020304 03043344 00000001 00000005 00000004
88020002 50607080 60708044 00000002 00000005 00000004
88020003 9ABCDEF0 9ABCDEF0 00000003 00000005 00000004
98020000 13579BDF 13579BDF 00000000 00000005 00000004
98020001 A1B2C3D4 13A1B2C3 00000001 00000005 00000004
98020002 0F1E2D3C 13A10F1E 00000002 00000005 00000004
98020003 FEDCBA98 13A10FFE 00000003 00000005 00000004
// test 5: dependent chain, illegal opcode and funct, idle cycles
240C0005 00000000 13A10FFE 00000000 00000001 00000005
018C6021 00000000 13A10FFE 00000000 00000001 00000005
018C1021 00000000 00000014 00000000 00000001 00000005
004C1021 00000000 0000001E 00000000 00000001 00000005
FC021234 00000000 0000001E 00000000 00000003 00000005
004C103F 00000000 0000001E 00000000 00000003 00000005
24420001 00000000 0000001F 00000000 00000001 00000005
24420001 00000000 0000001F 00000000 00000000 00000005
FC021234 00000000 0000001F 00000000 00000000 00000005
24420001 00000000 00000020 00000000 00000001 00000005
// end marker
00000000 00000000 00000000 00000000 00000000 00000000

//--- files.f
hdl/mipsPkg.sv
hdl/registers.sv
hdl/instrDecoder.sv
hdl/aluUnit.sv
hdl/execSlice.sv
test/clockGen.sv
test/execSliceTb.sv

//--- run.sh
#!/bin/sh
# build and run the execSlice testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module execSliceTb \
  -o execSliceSim || { echo "compile failed"; exit 1; }
./obj_dir/execSliceSim > sim.log 2>&1
cat sim.log
grep -qF '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

//--- test/execSliceTb.sv
`timescale 1ns/1ps

module execSliceTb;

  // six words per record in the vector file
  localparam int MAX_RECORDS  = 64;
  localparam int RECORD_WORDS = 6;

  logic        clk;
  logic        reset;
  logic        instrValid;
  logic [31:0] instr;
  logic [31:0] loadData;
  logic [31:0] memAddress;
  logic [31:0] registerV0;
  logic        illegalInstr;

  // instr, loadData, expected v0, expected address, flags, test number
  logic [31:0] vectorMem [0:MAX_RECORDS*RECORD_WORDS-1];

  int recordCount;
  int cycleLimit = MAX_RECORDS + 20;
  int cycleCount = 0;
  int currentTest;
  int recordIndex;
  int testChecks  = 0;
  int testErrors  = 0;
  int totalErrors = 0;
  int testsPassed = 0;
  int testsFailed = 0;

  clockGen clockSource (
    .clk   (clk),
    .reset (reset)
  );

  execSlice UUT (
    .clk          (clk),
    .reset        (reset),
    .instrValid   (instrValid),
    .instr        (instr),
    .loadData     (loadData),
    .memAddress   (memAddress),
    .registerV0   (registerV0),
    .illegalInstr (illegalInstr)
  );

  // compare one DUT output against the vector value
  task automatic checkValue(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    testChecks++;
    assert (actual === expected)
    else
    begin
      $display("FAILED at %0t: test %0d record %0d %s is %h, expected %h",
               $time, currentTest, recordIndex, what, actual, expected);
      testErrors++;
      totalErrors++;
    end
  endtask

  // one summary line per test
  task automatic finishTest();
    if (testErrors == 0)
    begin
      testsPassed++;
      $display("test %0d finished: %0d checks, all correct", currentTest, testChecks);
    end
    else
    begin
      testsFailed++;
      $display("test %0d finished: %0d of %0d checks wrong",
               currentTest, testErrors, testChecks);
    end
    testChecks = 0;
    testErrors = 0;
  endtask

  // watchdog, counts every clock from time zero
  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout: run did not finish within %0d clock cycles", cycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin : stimulus
    logic [31:0] flags;
    int          base;

    instrValid = 1'b0;
    instr      = 32'd0;
    loadData   = 32'd0;

    $readmemh("test/execVectors.txt", vectorMem);
    // a test number of zero marks the end of the vectors
    recordCount = 0;
    while (recordCount < MAX_RECORDS &&
           vectorMem[recordCount*RECORD_WORDS + 5] != 32'd0)
    begin
      recordCount++;
    end
    cycleLimit = recordCount + 20;
    if (recordCount == 0)
    begin
      $display("no vectors could be read from test/execVectors.txt");
      totalErrors++;
    end

    currentTest = vectorMem[5];
    recordIndex = 0;
    wait (reset == 1'b0);
    // registers are cleared by reset
    checkValue("registerV0 after reset", registerV0, 32'd0);

    @(posedge clk);
    #1;
    for (recordIndex = 0; recordIndex < recordCount; recordIndex++)
    begin
      base        = recordIndex * RECORD_WORDS;
      flags       = vectorMem[base + 4];
      currentTest = vectorMem[base + 5];
      // flags bit 0 is instrValid
      instrValid  = flags[0];
      instr       = vectorMem[base];
      loadData    = vectorMem[base + 1];

      // 1 ns before the next edge
      #6;
      checkValue("illegalInstr", {31'd0, illegalInstr}, {31'd0, flags[1]});
      if (flags[2])
        checkValue("memAddress", memAddress, vectorMem[base + 3]);

      // write lands on this edge
      @(posedge clk);
      #0.5;
      checkValue("registerV0", registerV0, vectorMem[base + 2]);

      if (recordIndex == recordCount - 1 ||
          vectorMem[base + RECORD_WORDS + 5] != vectorMem[base + 5])
        finishTest();
      #0.5;
    end

    instrValid = 1'b0;
    $display("tests passed %0d, tests failed %0d, wrong values %0d",
             testsPassed, testsFailed, totalErrors);
    if (totalErrors == 0 && testsFailed == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);

  // 8 ns period, first rising edge at 4 ns
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset covers the first two rising edges
  // and drops shortly after the second one
  initial
  begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- hdl/execSlice.sv
`timescale 1ns/1ps

module execSlice (
  input  logic        clk,
  input  logic        reset,
  input  logic        instrValid,
  input  logic [31:0] instr,
  // memory word for the address on memAddress this cycle
  input  logic [31:0] loadData,
  output logic [31:0] memAddress,
  output logic [31:0] registerV0,
  output logic        illegalInstr
);

  // decoder outputs
  logic [4:0]         readReg1;
  logic [4:0]         readReg2;
  logic [4:0]         writeReg;
  logic [15:0]        immediate;
  logic               useImmediate;
  logic               signedImmediate;
  logic               isLoad;
  mipsPkg::aluOpT     aluOp;
  mipsPkg::writeModeT writeMode;

  // datapath
  logic [31:0] readData1;
  logic [31:0] readData2;
  logic [31:0] aluResult;
  logic [31:0] writeData;

  instrDecoder decoder (
    .instrValid      (instrValid),
    .instr           (instr),
    .readReg1        (readReg1),
    .readReg2        (readReg2),
    .writeReg        (writeReg),
    .immediate       (immediate),
    .useImmediate    (useImmediate),
    .signedImmediate (signedImmediate),
    .isLoad          (isLoad),
    .aluOp           (aluOp),
    .writeMode       (writeMode),
    .illegalInstr    (illegalInstr)
  );

  aluUnit alu (
    .aluOp           (aluOp),
    .readData1       (readData1),
    .readData2       (readData2),
    .immediate       (immediate),
    .useImmediate    (useImmediate),
    .signedImmediate (signedImmediate),
    .aluResult       (aluResult)
  );

  // loads write the memory word, everything else the alu result
  assign writeData  = isLoad ? loadData : aluResult;
  // for loads the alu result is the effective address
  assign memAddress = aluResult;

  registers regs (
    .clk        (clk),
    .reset      (reset),
    .readReg1   (readReg1),
    .readReg2   (readReg2),
    .writeReg   (writeReg),
    .writeMode  (writeMode),
    .writeData  (writeData),
    .byteOffset (aluResult[1:0]),
    .readData1  (readData1),
    .readData2  (readData2),
    .registerV0 (registerV0)
  );

  // an illegal instruction leaves v0 untouched across its write edge
  assert property (@(posedge clk) disable iff (reset)
    illegalInstr |=> $stable(registerV0))
    else $error("v0 changed after an illegal instruction");

endmodule

//--- hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  mipsPkg::aluOpT       aluOp,
  input  logic          [31:0] readData1,
  input  logic          [31:0] readData2,
  input  logic          [15:0] immediate,
  input  logic                 useImmediate,
  input  logic                 signedImmediate,
  output logic          [31:0] aluResult
);

  // immediate widened to a full word
  logic [31:0] extImmediate;
  // second operand after the register or immediate choice
  logic [31:0] operandB;

  // sign extension for addiu and loads and zero extension for ori
  assign extImmediate = signedImmediate ? {{16{immediate[15]}}, immediate}
                                        : {16'd0, immediate};
  assign operandB     = useImmediate ? extImmediate : readData2;

  always_comb
  begin
    case (aluOp)
      // add also forms the load address
      mipsPkg::aluAdd: aluResult = readData1 + operandB;
      mipsPkg::aluSub: aluResult = readData1 - operandB;
      mipsPkg::aluAnd: aluResult = readData1 & operandB;
      mipsPkg::aluOr:  aluResult = readData1 | operandB;
      mipsPkg::aluXor: aluResult = readData1 ^ operandB;
      mipsPkg::aluSlt:
      begin
        // signed compare gives 0 or 1
        aluResult = ($signed(readData1) < $signed(operandB)) ? 32'd1 : 32'd0;
      end
      // immediate goes to the upper half, rs is ignored
      mipsPkg::aluLui: aluResult = {immediate, 16'd0};
      default:         aluResult = 32'd0;
    endcase
  end

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic               instrValid,
  input  logic [31:0]        instr,
  output logic [4:0]         readReg1,
  output logic [4:0]         readReg2,
  output logic [4:0]         writeReg,
  output logic [15:0]        immediate,
  output logic               useImmediate,
  output logic               signedImmediate,
  output logic               isLoad,
  output mipsPkg::aluOpT     aluOp,
  output mipsPkg::writeModeT writeMode,
  output logic               illegalInstr
);

  // instruction fields
  mipsPkg::opcodeT opcode;
  mipsPkg::functT  funct;
  logic [4:0]      rs;
  logic [4:0]      rt;
  logic [4:0]      rd;

  // decode results before the valid and legal gating
  mipsPkg::writeModeT decodedMode;
  logic               known;
  logic               rType;

  assign opcode    = mipsPkg::opcodeT'(instr[31:26]);
  assign funct     = mipsPkg::functT'(instr[5:0]);
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign immediate = instr[15:0];

  // rs and rt always feed the read ports
  assign readReg1 = rs;
  assign readReg2 = rt;
  // r-type writes rd and everything else writes rt
  assign writeReg = rType ? rd : rt;

  always_comb
  begin
    // defaults describe a plain add with no write
    aluOp           = mipsPkg::aluAdd;
    useImmediate    = 1'b0;
    signedImmediate = 1'b0;
    isLoad          = 1'b0;
    decodedMode     = mipsPkg::writeNone;
    known           = 1'b1;
    rType           = 1'b0;

    case (opcode)
      mipsPkg::opSpecial:
      begin
        rType       = 1'b1;
        decodedMode = mipsPkg::writeWord;
        // function field picks the operation
        case (funct)
          mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
          mipsPkg::fnXor:  aluOp = mipsPkg::aluXor;
          mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
          default:         known = 1'b0;
        endcase
      end
      mipsPkg::opAddiu:
      begin
        useImmediate    = 1'b1;
        signedImmediate = 1'b1;
        decodedMode     = mipsPkg::writeWord;
      end
      mipsPkg::opOri:
      begin
        // ori zero-extends its immediate
        aluOp        = mipsPkg::aluOr;
        useImmediate = 1'b1;
        decodedMode  = mipsPkg::writeWord;
      end
      mipsPkg::opLui:
      begin
        aluOp        = mipsPkg::aluLui;
        useImmediate = 1'b1;
        decodedMode  = mipsPkg::writeWord;
      end
      mipsPkg::opLw, mipsPkg::opLwl, mipsPkg::opLwr:
      begin
        // address is rs plus the sign-extended offset
        useImmediate    = 1'b1;
        signedImmediate = 1'b1;
        isLoad          = 1'b1;
        if (opcode == mipsPkg::opLwl)
          decodedMode = mipsPkg::writeLeft;
        else if (opcode == mipsPkg::opLwr)
          decodedMode = mipsPkg::writeRight;
        else
          decodedMode = mipsPkg::writeWord;
      end
      default:
      begin
        known = 1'b0;
      end
    endcase

    // strobe only for a live instruction
    illegalInstr = instrValid && !known;
    // nothing is written for idle cycles or unknown encodings
    writeMode = (instrValid && known) ? decodedMode : mipsPkg::writeNone;
  end

endmodule

//--- hdl/registers.sv
`timescale 1ns/1ps

module registers (
  input  logic              clk,
  input  logic              reset,
  // register numbers from the instruction fields
  input  logic [4:0]        readReg1,
  input  logic [4:0]        readReg2,
  input  logic [4:0]        writeReg,
  input  mipsPkg::writeModeT writeMode,
  input  logic [31:0]       writeData,
  // low two bits of the load address, used by lwl and lwr
  input  logic [1:0]        byteOffset,
  output logic [31:0]       readData1,
  output logic [31:0]       readData2,
  output logic [31:0]       registerV0
);

  // 32 general purpose registers
  logic [31:0] regFile [0:31];
  // value that actually lands in the target register
  logic [31:0] mergeData;

  // reads are combinational from the array
  // so the next instruction sees this edge's write
  assign readData1  = regFile[readReg1];
  assign readData2  = regFile[readReg2];
  assign registerV0 = regFile[mipsPkg::V0_REG];

  // byte merge for the unaligned loads
  // readData2 carries the old target value since rt is both source and dest
  always_comb
  begin
    case (writeMode)
      mipsPkg::writeLeft:
      begin
        // loaded low bytes go to the top of the register
        case (byteOffset)
          2'd0: mergeData = {writeData[7:0], readData2[23:0]};
          2'd1: mergeData = {writeData[15:0], readData2[15:0]};
          2'd2: mergeData = {writeData[23:0], readData2[7:0]};
          default: mergeData = writeData;
        endcase
      end
      mipsPkg::writeRight:
      begin
        // loaded high bytes go to the bottom of the register
        case (byteOffset)
          2'd0: mergeData = writeData;
          2'd1: mergeData = {readData2[31:24], writeData[31:8]};
          2'd2: mergeData = {readData2[31:16], writeData[31:16]};
          default: mergeData = {readData2[31:8], writeData[31:24]};
        endcase
      end
      default:
      begin
        // whole word, also harmless for writeNone
        mergeData = writeData;
      end
    endcase
  end

  // write port
  // reset wins over a write in the same cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regFile[i] <= 32'd0;
      end
    end
    else if (writeMode != mipsPkg::writeNone && writeReg != 5'd0)
    begin
      // register 0 is never written, it stays at its reset value
      regFile[writeReg] <= mergeData;
    end
  end

  // zero register holds zero for the whole run after reset
  assert property (@(posedge clk) disable iff (reset)
    (readReg1 == 5'd0) |-> (readData1 == 32'd0))
    else $error("register 0 read nonzero on port 1");

  assert property (@(posedge clk) disable iff (reset)
    (readReg2 == 5'd0) |-> (readData2 == 32'd0))
    else $error("register 0 read nonzero on port 2");

  // merges need the old target on port 2
  // decoder must route rt to both readReg2 and writeReg
  assert property (@(posedge clk) disable iff (reset)
    (writeMode == mipsPkg::writeLeft || writeMode == mipsPkg::writeRight)
    |-> (readReg2 == writeReg))
    else $error("merge write without old target on read port 2");

endmodule

//--- hdl/mipsPkg.sv
package mipsPkg;

  // primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    opSpecial = 6'h00,
    opAddiu   = 6'h09,
    opOri     = 6'h0d,
    opLui     = 6'h0f,
    opLwl     = 6'h22,
    opLw      = 6'h23,
    opLwr     = 6'h26
  } opcodeT;

  // function field for special opcode, bits 5:0
  typedef enum logic [5:0] {
    fnAddu = 6'h21,
    fnSubu = 6'h23,
    fnAnd  = 6'h24,
    fnOr   = 6'h25,
    fnXor  = 6'h26,
    fnSlt  = 6'h2a
  } functT;

  // operations the alu knows about
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluXor = 3'd4,
    aluSlt = 3'd5,
    aluLui = 3'd6
  } aluOpT;

  // how the register file takes the write data
  // left and right merge with the old target value
  typedef enum logic [1:0] {
    writeNone  = 2'b00,
    writeLeft  = 2'b01,
    writeRight = 2'b10,
    writeWord  = 2'b11
  } writeModeT;

  // v0 holds the observed result
  localparam logic [4:0] V0_REG = 5'd2;

endpackage
